// File: flist.f
hw/rob_pkg.sv
hw/rob_entry.sv
hw/rob.sv
hw/rat.sv
hw/rob_subsys_top.sv
tests/rob_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the ROB subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module rob_tb -o rob_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/rob_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Test failed" sim.log; then
   exit 1
fi
exit 0

// File: tests/rob_tb.sv
`timescale 1ns/1ps

module rob_tb;

   import rob_pkg::*;

   localparam int NSTEPS = 5;

   logic       clk;
   logic       reset;
   logic       alloc;
   logic       alloc_dst_valid;
   logic [3:0] alloc_dst_reg;
   logic       alloc_ready;
   logic [3:0] alloc_robid;
   logic [4:0] alloc_pdst;
   logic       ex_complete;
   logic [3:0] ex_robid;
   logic       ex_flush;
   logic       ex_mispred;
   logic       mm_complete;
   logic [3:0] mm_robid;
   logic       mm_flush;
   logic       mm_mispred;
   logic [3:0] src_reg     [2];
   logic       src_pending [2];
   logic [3:0] src_robid   [2];
   logic       retire;
   logic       reclaim_valid;
   logic [4:0] reclaim_prf;
   logic       nuke;
   t_nuke_type nuke_type;
   logic       restore_valid;
   logic [3:0] restore_reg;
   logic [4:0] restore_prf;
   logic       resume_fetch;
   logic [3:0] oldest_robid;

   // Step table of ops, destinations, flush point and source lookups
   string      step_name  [NSTEPS];
   int         step_nops  [NSTEPS];
   logic [7:0] step_dmask [NSTEPS];
   logic [3:0] step_dreg  [NSTEPS][8];
   int         step_flush [NSTEPS];
   logic       step_mis   [NSTEPS];
   t_nuke_type step_nuke  [NSTEPS];
   logic [3:0] step_src   [NSTEPS][2];

   // Behavioral rename model
   logic [4:0]  m_map [16];
   logic [31:0] m_free;
   logic [3:0]  m_tail;
   logic [3:0]  op_robid [8];
   logic        op_dv    [8];
   logic [3:0]  op_reg   [8];
   logic [4:0]  op_old   [8];
   logic [4:0]  op_new   [8];
   int          order    [8];

   logic [15:0] lfsr;
   string       cur_name;
   int          err_count;
   int          step_err;
   int          fail_steps;

   rob_subsys_top u_dut (.*);

   always #10 clk = ~clk;

   initial begin
      #2ms;
      $display("Simulation watchdog expired before the test sequence ended");
      $display("Test failed");
      $finish;
   end

   function automatic int take_bits(input int n);
      int val;
      logic lsb;
      val = 0;
      for (int b = 0; b < n; b++) begin
         lsb  = lfsr[0];
         lfsr = lfsr >> 1;
         if (lsb) lfsr = lfsr ^ 16'hB400;
         val = (val << 1) | int'(lsb);
      end
      return val;
   endfunction

   function automatic logic [4:0] lowest_free();
      for (int p = 0; p < 32; p++) begin
         if (m_free[p]) return 5'(p);
      end
      return 5'd0;
   endfunction

   task automatic report(input string what);
      $display("%s: %s", cur_name, what);
      err_count++;
      step_err++;
   endtask

   task automatic check_bit(input string what, input logic exp, input logic act);
      if (exp !== act) begin
         $display("MISMATCH %s %s: expected %0b actual %0b", cur_name, what, exp, act);
         err_count++;
         step_err++;
      end
   endtask

   task automatic check_prf(input string what, input logic [4:0] exp, input logic [4:0] act);
      if (exp !== act) begin
         $display("MISMATCH %s %s: expected %0d actual %0d", cur_name, what, exp, act);
         err_count++;
         step_err++;
      end
   endtask

   task automatic check_robid(input string what, input logic [3:0] exp, input logic [3:0] act);
      if (exp !== act) begin
         $display("MISMATCH %s %s: expected %0h actual %0h", cur_name, what, exp, act);
         err_count++;
         step_err++;
      end
   endtask

   task automatic check_nuke(input string what, input t_nuke_type exp, input t_nuke_type act);
      if (exp !== act) begin
         $display("MISMATCH %s %s: expected %s actual %s", cur_name, what, exp.name(),
                  act.name());
         err_count++;
         step_err++;
      end
   endtask

   task automatic set_step(input int s, input string nm, input int n, input logic [7:0] dmask,
                           input logic [31:0] regs, input int fl, input logic mis,
                           input logic [3:0] s0, input logic [3:0] s1);
      step_name[s]  = nm;
      step_nops[s]  = n;
      step_dmask[s] = dmask;
      for (int i = 0; i < 8; i++) begin
         step_dreg[s][i] = regs[i*4 +: 4];
      end
      step_flush[s]  = fl;
      step_mis[s]    = mis;
      step_nuke[s]   = mis ? NUKE_BR_MISPRED : NUKE_EXCEPTION;
      step_src[s][0] = s0;
      step_src[s][1] = s1;
   endtask

   // Register lists are written op 7 down to op 0
   task automatic fill_table();
      set_step(0, "in_order_retire", 5, 8'b1011_0111, 32'h0000_4312, -1, 1'b0, 4'd1, 4'd9);
      set_step(1, "backpressure_wrap", 8, 8'b1111_1011, 32'h2857_5655, -1, 1'b0, 4'd5,
               4'd11);
      set_step(2, "mispredict_flush", 6, 8'b0010_1111, 32'h00A3_9343, 1, 1'b1, 4'd3, 4'd12);
      set_step(3, "exception_flush", 5, 8'b0001_1111, 32'h0007_6766, 2, 1'b0, 4'd6, 4'd7);
      set_step(4, "repaired_map", 4, 8'b0000_1111, 32'h0000_1676, -1, 1'b0, 4'd7, 4'd0);
   endtask

   task automatic alloc_ops(input int s);
      int t;
      for (int i = 0; i < step_nops[s]; i++) begin
         t = 0;
         while (t < 50) begin
            @(posedge clk);
            #1;
            // The op driven in the last cycle was taken at this edge
            alloc = 1'b0;
            if (alloc_ready) break;
            t++;
         end
         if (t >= 50) begin
            report("alloc_ready never rose for the next allocation");
            return;
         end
         op_dv[i]        = step_dmask[s][i];
         op_reg[i]       = step_dreg[s][i];
         alloc           = 1'b1;
         alloc_dst_valid = op_dv[i];
         alloc_dst_reg   = op_reg[i];
         #1;
         check_robid("alloc_robid", m_tail, alloc_robid);
         op_robid[i] = m_tail;
         m_tail      = m_tail + 4'd1;
         if (op_dv[i]) begin
            check_prf("alloc_pdst", lowest_free(), alloc_pdst);
            op_new[i]          = lowest_free();
            op_old[i]          = m_map[op_reg[i]];
            m_map[op_reg[i]]   = op_new[i];
            m_free[op_new[i]]  = 1'b0;
         end
      end
      @(posedge clk);
      #1;
      alloc = 1'b0;
   endtask

   task automatic check_sources(input int s);
      logic       pend;
      logic [3:0] id;
      for (int k = 0; k < 2; k++) begin
         src_reg[k] = step_src[s][k];
      end
      #1;
      for (int k = 0; k < 2; k++) begin
         pend = 1'b0;
         id   = '0;
         for (int i = 0; i < step_nops[s]; i++) begin
            if (op_dv[i] && op_reg[i] == step_src[s][k]) begin
               pend = 1'b1;
               id   = op_robid[i];
            end
         end
         check_bit($sformatf("src_pending[%0d]", k), pend, src_pending[k]);
         if (pend) check_robid($sformatf("src_robid[%0d]", k), id, src_robid[k]);
      end
      if (step_nops[s] == 8) check_bit("alloc_ready when full", 1'b0, alloc_ready);
   endtask

   task automatic drive_completions(input int s);
      int j;
      int tmp;
      int port;
      for (int i = 0; i < step_nops[s]; i++) order[i] = i;
      for (int i = step_nops[s] - 1; i > 0; i--) begin
         j        = take_bits(3) % (i + 1);
         tmp      = order[i];
         order[i] = order[j];
         order[j] = tmp;
      end
      for (int i = 0; i < step_nops[s]; i++) begin
         port = take_bits(1);
         @(posedge clk);
         #1;
         ex_complete = 1'b0;
         mm_complete = 1'b0;
         if (port == 0) begin
            ex_complete = 1'b1;
            ex_robid    = op_robid[order[i]];
            ex_flush    = (order[i] == step_flush[s]);
            ex_mispred  = ex_flush & step_mis[s];
         end else begin
            mm_complete = 1'b1;
            mm_robid    = op_robid[order[i]];
            mm_flush    = (order[i] == step_flush[s]);
            mm_mispred  = mm_flush & step_mis[s];
         end
      end
      @(posedge clk);
      #1;
      ex_complete = 1'b0;
      mm_complete = 1'b0;
   endtask

   task automatic watch_retire(input int s);
      int t;
      int last;
      int fl;
      fl   = step_flush[s];
      last = (fl >= 0) ? fl : step_nops[s] - 1;
      for (int i = 0; i <= last; i++) begin
         t = 0;
         do begin
            @(negedge clk);
            // One retirement out of a full ROB reopens allocation
            if (t == 0 && i == 1 && step_nops[s] == 8) begin
               check_bit("alloc_ready after retire", 1'b1, alloc_ready);
            end
            t++;
         end while (!retire && t < 100);
         if (!retire) begin
            report($sformatf("op %0d never retired", i));
            return;
         end
         check_robid("oldest_robid", op_robid[i], oldest_robid);
         check_bit("reclaim_valid", op_dv[i], reclaim_valid);
         if (op_dv[i]) begin
            check_prf("reclaim_prf", op_old[i], reclaim_prf);
            m_free[op_old[i]] = 1'b1;
         end
         check_bit("nuke", (i == fl), nuke);
      end
      if (fl < 0) return;
      check_nuke("nuke_type", step_nuke[s], nuke_type);
      m_tail = op_robid[fl] + 4'd1;
      repeat (5) begin
         @(negedge clk);
         check_bit("restore_valid while quiet", 1'b0, restore_valid);
         check_bit("resume_fetch while quiet", 1'b0, resume_fetch);
         check_bit("alloc_ready while quiet", 1'b0, alloc_ready);
      end
      // Each restore undoes one rename in youngest-first order
      for (int i = step_nops[s] - 1; i > fl; i--) begin
         @(negedge clk);
         check_bit("restore_valid", op_dv[i], restore_valid);
         check_bit("alloc_ready during walk", 1'b0, alloc_ready);
         if (op_dv[i]) begin
            check_robid("restore_reg", op_reg[i], restore_reg);
            check_prf("restore_prf", op_old[i], restore_prf);
            m_free[m_map[op_reg[i]]] = 1'b1;
            m_map[op_reg[i]]         = op_old[i];
         end
      end
      @(negedge clk);
      check_bit("resume_fetch", 1'b1, resume_fetch);
      check_bit("alloc_ready at resume", 1'b0, alloc_ready);
      @(negedge clk);
      check_bit("resume_fetch after pulse", 1'b0, resume_fetch);
      check_bit("alloc_ready after resume", 1'b1, alloc_ready);
   endtask

   initial begin
      clk             = 1'b0;
      reset           = 1'b1;
      alloc           = 1'b0;
      alloc_dst_valid = 1'b0;
      alloc_dst_reg   = '0;
      ex_complete     = 1'b0;
      ex_robid        = '0;
      ex_flush        = 1'b0;
      ex_mispred      = 1'b0;
      mm_complete     = 1'b0;
      mm_robid        = '0;
      mm_flush        = 1'b0;
      mm_mispred      = 1'b0;
      src_reg[0]      = '0;
      src_reg[1]      = '0;
      lfsr            = 16'd98;
      err_count       = 0;
      fail_steps      = 0;
      m_tail          = '0;
      for (int r = 0; r < 16; r++) m_map[r] = 5'(r);
      m_free = 32'hFFFF_0000;
      fill_table();
      repeat (10) @(posedge clk);
      #1;
      reset = 1'b0;
      cur_name = "reset";
      step_err = 0;
      #1;
      check_bit("alloc_ready", 1'b1, alloc_ready);
      check_bit("retire", 1'b0, retire);
      check_bit("nuke", 1'b0, nuke);
      check_bit("restore_valid", 1'b0, restore_valid);
      check_bit("reclaim_valid", 1'b0, reclaim_valid);
      check_bit("resume_fetch", 1'b0, resume_fetch);
      for (int s = 0; s < NSTEPS; s++) begin
         cur_name = step_name[s];
         step_err = 0;
         alloc_ops(s);
         check_sources(s);
         @(posedge clk);
         fork
            drive_completions(s);
            watch_retire(s);
         join
         if (step_err != 0) fail_steps++;
         $display("%s: %s (%0d errors)", cur_name, (step_err == 0) ? "ok" : "FAILED", step_err);
      end
      $display("Steps run %0d, steps failed %0d, errors %0d", NSTEPS, fail_steps, err_count);
      if (err_count == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// File: hw/rob_subsys_top.sv
`timescale 1ns/1ps

module rob_subsys_top #(
   parameter  int ROB_ENTRIES    = rob_pkg::DEF_ROB_ENTRIES,
   parameter  int NUM_SOURCES    = rob_pkg::DEF_NUM_SOURCES,
   parameter  int ARCH_REGS      = rob_pkg::DEF_ARCH_REGS,
   parameter  int PRF_ENTRIES    = rob_pkg::DEF_PRF_ENTRIES,
   parameter  int QUIESCE_CYCLES = rob_pkg::DEF_QUIESCE_CYCLES,
   localparam int RW             = $clog2(ROB_ENTRIES) + 1,
   localparam int AW             = $clog2(ARCH_REGS),
   localparam int PW             = $clog2(PRF_ENTRIES)
) (
   input  logic                clk,
   input  logic                reset,
   input  logic                alloc,
   input  logic                alloc_dst_valid,
   input  logic [AW-1:0]       alloc_dst_reg,
   output logic                alloc_ready,
   output logic [RW-1:0]       alloc_robid,
   output logic [PW-1:0]       alloc_pdst,
   input  logic                ex_complete,
   input  logic [RW-1:0]       ex_robid,
   input  logic                ex_flush,
   input  logic                ex_mispred,
   input  logic                mm_complete,
   input  logic [RW-1:0]       mm_robid,
   input  logic                mm_flush,
   input  logic                mm_mispred,
   input  logic [AW-1:0]       src_reg     [NUM_SOURCES],
   output logic                src_pending [NUM_SOURCES],
   output logic [RW-1:0]       src_robid   [NUM_SOURCES],
   output logic                retire,
   output logic                reclaim_valid,
   output logic [PW-1:0]       reclaim_prf,
   output logic                nuke,
   output rob_pkg::t_nuke_type nuke_type,
   output logic                restore_valid,
   output logic [AW-1:0]       restore_reg,
   output logic [PW-1:0]       restore_prf,
   output logic                resume_fetch,
   output logic [RW-1:0]       oldest_robid
);

   logic          rob_ready;
   logic          rob_alloc;
   logic          rename_valid_rn1;
   logic [PW-1:0] pdst_old_rn1;

   rat #(
      .ARCH_REGS   (ARCH_REGS),
      .PRF_ENTRIES (PRF_ENTRIES)
   ) u_rat (
      .clk              (clk),
      .reset            (reset),
      .alloc            (alloc),
      .alloc_dst_valid  (alloc_dst_valid),
      .alloc_dst_reg    (alloc_dst_reg),
      .rob_ready        (rob_ready),
      .reclaim_valid    (reclaim_valid),
      .reclaim_prf      (reclaim_prf),
      .restore_valid    (restore_valid),
      .restore_reg      (restore_reg),
      .restore_prf      (restore_prf),
      .alloc_ready      (alloc_ready),
      .rob_alloc        (rob_alloc),
      .alloc_pdst       (alloc_pdst),
      .rename_valid_rn1 (rename_valid_rn1),
      .pdst_old_rn1     (pdst_old_rn1)
   );

   rob #(
      .ROB_ENTRIES    (ROB_ENTRIES),
      .NUM_SOURCES    (NUM_SOURCES),
      .ARCH_REGS      (ARCH_REGS),
      .PRF_ENTRIES    (PRF_ENTRIES),
      .QUIESCE_CYCLES (QUIESCE_CYCLES)
   ) u_rob (
      .clk              (clk),
      .reset            (reset),
      .rob_alloc        (rob_alloc),
      .dst_valid        (alloc_dst_valid),
      .dst_reg          (alloc_dst_reg),
      .rename_valid_rn1 (rename_valid_rn1),
      .pdst_old_rn1     (pdst_old_rn1),
      .ex_complete      (ex_complete),
      .ex_robid         (ex_robid),
      .ex_flush         (ex_flush),
      .ex_mispred       (ex_mispred),
      .mm_complete      (mm_complete),
      .mm_robid         (mm_robid),
      .mm_flush         (mm_flush),
      .mm_mispred       (mm_mispred),
      .src_reg          (src_reg),
      .rob_ready        (rob_ready),
      .next_robid       (alloc_robid),
      .oldest_robid     (oldest_robid),
      .retire           (retire),
      .reclaim_valid    (reclaim_valid),
      .reclaim_prf      (reclaim_prf),
      .nuke             (nuke),
      .nuke_type        (nuke_type),
      .restore_valid    (restore_valid),
      .restore_reg      (restore_reg),
      .restore_prf      (restore_prf),
      .resume_fetch     (resume_fetch),
      .src_pending      (src_pending),
      .src_robid        (src_robid)
   );

endmodule

// File: hw/rat.sv
`timescale 1ns/1ps

module rat #(
   parameter  int ARCH_REGS   = rob_pkg::DEF_ARCH_REGS,
   parameter  int PRF_ENTRIES = rob_pkg::DEF_PRF_ENTRIES,
   localparam int AW          = $clog2(ARCH_REGS),
   localparam int PW          = $clog2(PRF_ENTRIES)
) (
   input  logic          clk,
   input  logic          reset,
   input  logic          alloc,
   input  logic          alloc_dst_valid,
   input  logic [AW-1:0] alloc_dst_reg,
   input  logic          rob_ready,
   input  logic          reclaim_valid,
   input  logic [PW-1:0] reclaim_prf,
   input  logic          restore_valid,
   input  logic [AW-1:0] restore_reg,
   input  logic [PW-1:0] restore_prf,
   output logic          alloc_ready,
   output logic          rob_alloc,
   output logic [PW-1:0] alloc_pdst,
   output logic          rename_valid_rn1,
   output logic [PW-1:0] pdst_old_rn1
);

   logic [PW-1:0]          map [ARCH_REGS];
   logic [PRF_ENTRIES-1:0] free;
   logic [PRF_ENTRIES-1:0] free_nxt;
   logic                   free_any;
   logic [PW-1:0]          free_idx;
   logic                   take;

   // Lowest-numbered free physical register
   always_comb begin
      free_any = 1'b0;
      free_idx = '0;
      for (int p = PRF_ENTRIES - 1; p >= 0; p--) begin
         if (free[p]) begin
            free_any = 1'b1;
            free_idx = PW'(p);
         end
      end
   end

   assign alloc_ready = rob_ready & free_any;
   assign rob_alloc   = alloc & alloc_ready;
   assign alloc_pdst  = free_idx;
   assign take        = rob_alloc & alloc_dst_valid;

   // Restore frees the mapping being undone before the map is rewritten
   always_comb begin
      free_nxt = free;
      if (take) begin
         free_nxt[free_idx] = 1'b0;
      end
      if (reclaim_valid) begin
         free_nxt[reclaim_prf] = 1'b1;
      end
      if (restore_valid) begin
         free_nxt[map[restore_reg]] = 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int r = 0; r < ARCH_REGS; r++) begin
            map[r] <= PW'(r);
         end
         for (int p = 0; p < PRF_ENTRIES; p++) begin
            free[p] <= (p >= ARCH_REGS);
         end
         rename_valid_rn1 <= 1'b0;
      end else begin
         free             <= free_nxt;
         rename_valid_rn1 <= take;
         // restore and alloc never overlap since rob_ready is low during a walk
         if (restore_valid) begin
            map[restore_reg] <= restore_prf;
         end else if (take) begin
            map[alloc_dst_reg] <= free_idx;
         end
      end
   end

   // Old mapping goes out one cycle after the rename
   always_ff @(posedge clk) begin
      if (take) begin
         pdst_old_rn1 <= map[alloc_dst_reg];
      end
   end

endmodule

// File: hw/rob.sv
`timescale 1ns/1ps

module rob #(
   parameter  int ROB_ENTRIES    = rob_pkg::DEF_ROB_ENTRIES,
   parameter  int NUM_SOURCES    = rob_pkg::DEF_NUM_SOURCES,
   parameter  int ARCH_REGS      = rob_pkg::DEF_ARCH_REGS,
   parameter  int PRF_ENTRIES    = rob_pkg::DEF_PRF_ENTRIES,
   parameter  int QUIESCE_CYCLES = rob_pkg::DEF_QUIESCE_CYCLES,
   localparam int IW             = $clog2(ROB_ENTRIES),
   localparam int RW             = IW + 1,
   localparam int AW             = $clog2(ARCH_REGS),
   localparam int PW             = $clog2(PRF_ENTRIES)
) (
   input  logic                clk,
   input  logic                reset,
   input  logic                rob_alloc,
   input  logic                dst_valid,
   input  logic [AW-1:0]       dst_reg,
   input  logic                rename_valid_rn1,
   input  logic [PW-1:0]       pdst_old_rn1,
   input  logic                ex_complete,
   input  logic [RW-1:0]       ex_robid,
   input  logic                ex_flush,
   input  logic                ex_mispred,
   input  logic                mm_complete,
   input  logic [RW-1:0]       mm_robid,
   input  logic                mm_flush,
   input  logic                mm_mispred,
   input  logic [AW-1:0]       src_reg     [NUM_SOURCES],
   output logic                rob_ready,
   output logic [RW-1:0]       next_robid,
   output logic [RW-1:0]       oldest_robid,
   output logic                retire,
   output logic                reclaim_valid,
   output logic [PW-1:0]       reclaim_prf,
   output logic                nuke,
   output rob_pkg::t_nuke_type nuke_type,
   output logic                restore_valid,
   output logic [AW-1:0]       restore_reg,
   output logic [PW-1:0]       restore_prf,
   output logic                resume_fetch,
   output logic                src_pending [NUM_SOURCES],
   output logic [RW-1:0]       src_robid   [NUM_SOURCES]
);

   import rob_pkg::*;

   localparam int CW = $clog2(QUIESCE_CYCLES + 1);

   logic [RW-1:0]          head;
   logic [RW-1:0]          tail;
   logic [IW-1:0]          head_idx;
   logic                   empty;
   logic                   full;

   logic [ROB_ENTRIES-1:0] e_alloc;
   logic [ROB_ENTRIES-1:0] e_retire;
   logic [ROB_ENTRIES-1:0] e_clr_young;
   logic [ROB_ENTRIES-1:0] e_valid;
   logic [ROB_ENTRIES-1:0] e_ready;
   logic [ROB_ENTRIES-1:0] e_flush;
   logic [ROB_ENTRIES-1:0] e_mispred;
   logic [ROB_ENTRIES-1:0] e_dst_valid;
   logic [AW-1:0]          e_dst_reg  [ROB_ENTRIES];
   logic [PW-1:0]          e_pdst_old [ROB_ENTRIES];

   t_rr_state              rr_state;
   logic [CW-1:0]          rr_cnt;
   logic [RW-1:0]          rr_ptr;
   logic [RW-1:0]          walk_id;
   logic [IW-1:0]          walk_idx;

   assign head_idx     = head[IW-1:0];
   assign empty        = (head == tail);
   assign full         = (head[IW-1:0] == tail[IW-1:0]) & (head[IW] != tail[IW]);
   assign next_robid   = tail;
   assign oldest_robid = head;

   // No allocation from the flush cycle until the repair is over
   assign rob_ready = ~full & ~nuke & (rr_state == RR_IDLE);

   // Head retirement
   assign retire        = ~empty & e_valid[head_idx] & e_ready[head_idx];
   assign nuke          = retire & e_flush[head_idx];
   assign nuke_type     = e_mispred[head_idx] ? NUKE_BR_MISPRED : NUKE_EXCEPTION;
   assign reclaim_valid = retire & e_dst_valid[head_idx];
   assign reclaim_prf   = e_pdst_old[head_idx];

   always_ff @(posedge clk) begin
      if (reset) begin
         head <= '0;
         tail <= '0;
      end else begin
         if (retire) begin
            head <= head + RW'(1);
         end
         // A flush drops everything younger than the retiring head
         if (nuke) begin
            tail <= head + RW'(1);
         end else if (rob_alloc) begin
            tail <= tail + RW'(1);
         end
      end
   end

   for (genvar i = 0; i < ROB_ENTRIES; i++) begin : g_entry
      assign e_alloc[i]     = rob_alloc & (tail[IW-1:0] == IW'(i));
      assign e_retire[i]    = retire & (head_idx == IW'(i));
      // Every valid entry other than the head is younger than it
      assign e_clr_young[i] = nuke & (head_idx != IW'(i));

      rob_entry #(
         .ROB_ENTRIES (ROB_ENTRIES),
         .ARCH_REGS   (ARCH_REGS),
         .PRF_ENTRIES (PRF_ENTRIES)
      ) u_entry (
         .clk               (clk),
         .reset             (reset),
         .e_valid_clr_young (e_clr_young[i]),
         .e_alloc           (e_alloc[i]),
         .dst_valid         (dst_valid),
         .dst_reg           (dst_reg),
         .rename_valid_rn1  (rename_valid_rn1),
         .pdst_old_rn1      (pdst_old_rn1),
         .ex_complete       (ex_complete),
         .ex_robid          (ex_robid),
         .ex_flush          (ex_flush),
         .ex_mispred        (ex_mispred),
         .mm_complete       (mm_complete),
         .mm_robid          (mm_robid),
         .mm_flush          (mm_flush),
         .mm_mispred        (mm_mispred),
         .e_retire          (e_retire[i]),
         .robid_index       (IW'(i)),
         .e_valid           (e_valid[i]),
         .e_ready           (e_ready[i]),
         .e_flush           (e_flush[i]),
         .e_mispred         (e_mispred[i]),
         .e_dst_valid       (e_dst_valid[i]),
         .e_dst_reg         (e_dst_reg[i]),
         .e_pdst_old        (e_pdst_old[i])
      );
   end

   // Youngest in-flight writer, searched from the tail toward the head
   always_comb begin
      logic [RW-1:0] cand;
      cand = '0;
      for (int s = 0; s < NUM_SOURCES; s++) begin
         src_pending[s] = 1'b0;
         src_robid[s]   = '0;
         for (int k = 1; k <= ROB_ENTRIES; k++) begin
            cand = tail - RW'(k);
            if (!src_pending[s] && e_valid[cand[IW-1:0]] && e_dst_valid[cand[IW-1:0]] &&
                (e_dst_reg[cand[IW-1:0]] == src_reg[s])) begin
               src_pending[s] = 1'b1;
               src_robid[s]   = cand;
            end
         end
      end
   end

   // Restore walk, rr_ptr holds one past the entry being restored
   assign walk_id  = rr_ptr - RW'(1);
   assign walk_idx = walk_id[IW-1:0];

   always_ff @(posedge clk) begin
      if (reset) begin
         rr_state <= RR_IDLE;
         rr_cnt   <= '0;
         rr_ptr   <= '0;
      end else begin
         case (rr_state)
            RR_IDLE: begin
               if (nuke) begin
                  rr_state <= RR_QUIET;
                  rr_cnt   <= CW'(QUIESCE_CYCLES - 1);
                  rr_ptr   <= tail;
               end
            end
            RR_QUIET: begin
               if (rr_cnt == '0) begin
                  // Head already sits past the faulting op; equal means nothing younger
                  rr_state <= (rr_ptr == head) ? RR_RESUME : RR_WALK;
               end else begin
                  rr_cnt <= rr_cnt - CW'(1);
               end
            end
            RR_WALK: begin
               rr_ptr <= walk_id;
               if (walk_id == head) begin
                  rr_state <= RR_RESUME;
               end
            end
            default: begin
               rr_state <= RR_IDLE;
            end
         endcase
      end
   end

   assign restore_valid = (rr_state == RR_WALK) & e_dst_valid[walk_idx];
   assign restore_reg   = e_dst_reg[walk_idx];
   assign restore_prf   = e_pdst_old[walk_idx];
   assign resume_fetch  = (rr_state == RR_RESUME);

endmodule

// File: hw/rob_entry.sv
`timescale 1ns/1ps

module rob_entry #(
   parameter  int ROB_ENTRIES = rob_pkg::DEF_ROB_ENTRIES,
   parameter  int ARCH_REGS   = rob_pkg::DEF_ARCH_REGS,
   parameter  int PRF_ENTRIES = rob_pkg::DEF_PRF_ENTRIES,
   localparam int IW          = $clog2(ROB_ENTRIES),
   localparam int RW          = IW + 1,
   localparam int AW          = $clog2(ARCH_REGS),
   localparam int PW          = $clog2(PRF_ENTRIES)
) (
   input  logic          clk,
   input  logic          reset,
   input  logic          e_valid_clr_young,
   input  logic          e_alloc,
   input  logic          dst_valid,
   input  logic [AW-1:0] dst_reg,
   input  logic          rename_valid_rn1,
   input  logic [PW-1:0] pdst_old_rn1,
   input  logic          ex_complete,
   input  logic [RW-1:0] ex_robid,
   input  logic          ex_flush,
   input  logic          ex_mispred,
   input  logic          mm_complete,
   input  logic [RW-1:0] mm_robid,
   input  logic          mm_flush,
   input  logic          mm_mispred,
   input  logic          e_retire,
   input  logic [IW-1:0] robid_index,
   output logic          e_valid,
   output logic          e_ready,
   output logic          e_flush,
   output logic          e_mispred,
   output logic          e_dst_valid,
   output logic [AW-1:0] e_dst_reg,
   output logic [PW-1:0] e_pdst_old
);

   logic ex_hit;
   logic mm_hit;
   logic rename_pending;

   // Completions select the entry by index; the wrap bit is not needed here
   assign ex_hit = ex_complete & (ex_robid[IW-1:0] == robid_index);
   assign mm_hit = mm_complete & (mm_robid[IW-1:0] == robid_index);

   always_ff @(posedge clk) begin
      if (reset) begin
         e_valid        <= 1'b0;
         e_ready        <= 1'b0;
         e_flush        <= 1'b0;
         e_mispred      <= 1'b0;
         rename_pending <= 1'b0;
      end else begin
         if (e_alloc) begin
            e_valid   <= 1'b1;
            e_ready   <= 1'b0;
            e_flush   <= 1'b0;
            e_mispred <= 1'b0;
         end else if (e_retire | e_valid_clr_young) begin
            e_valid <= 1'b0;
         end else if (e_valid & (ex_hit | mm_hit)) begin
            e_ready   <= 1'b1;
            e_flush   <= (ex_hit & ex_flush) | (mm_hit & mm_flush);
            e_mispred <= (ex_hit & ex_mispred) | (mm_hit & mm_mispred);
         end

         // The rename result always belongs to the previous cycle's alloc
         if (e_alloc) begin
            rename_pending <= dst_valid;
         end else if (rename_valid_rn1) begin
            rename_pending <= 1'b0;
         end
      end
   end

   // Destination fields outlive valid so the restore walk can read them
   always_ff @(posedge clk) begin
      if (e_alloc) begin
         e_dst_valid <= dst_valid;
         e_dst_reg   <= dst_reg;
      end
      if (rename_pending & rename_valid_rn1) begin
         e_pdst_old <= pdst_old_rn1;
      end
   end

endmodule

// File: hw/rob_pkg.sv
package rob_pkg;

   // Kind of pipeline flush raised by the retiring head
   typedef enum logic {
      NUKE_BR_MISPRED,
      NUKE_EXCEPTION
   } t_nuke_type;

   // RAT repair sequence after a flush
   typedef enum logic [1:0] {
      RR_IDLE,
      RR_QUIET,
      RR_WALK,
      RR_RESUME
   } t_rr_state;

   // Default sizes, overridden from the subsystem top
   localparam int DEF_ROB_ENTRIES    = 8;
   localparam int DEF_NUM_SOURCES    = 2;
   localparam int DEF_ARCH_REGS      = 16;
   localparam int DEF_PRF_ENTRIES    = 32;

   // Cycles the core is given to drain before the map is repaired
   localparam int DEF_QUIESCE_CYCLES = 5;

endpackage
